// File: sources.f
+incdir+hw
hw/lmem_pkg.sv
hw/lmem_elastic_buf.sv
hw/lmem_bank_dispatch.sv
hw/lmem_bank.sv
hw/lmem_rsp_collect.sv
hw/lmem_rsp_arb.sv
hw/lmem_unit.sv
tb/lmem_tb_clkgen.sv
tb/lmem_unit_assertions.sv
tb/lmem_unit_tb.sv

// File: Bender.yml
package:
  name: lmem_unit

export_include_dirs:
  - hw

sources:
  - files:
      - hw/lmem_pkg.sv
      - hw/lmem_elastic_buf.sv
      - hw/lmem_bank_dispatch.sv
      - hw/lmem_bank.sv
      - hw/lmem_rsp_collect.sv
      - hw/lmem_rsp_arb.sv
      - hw/lmem_unit.sv
  - target: test
    files:
      - tb/lmem_tb_clkgen.sv
      - tb/lmem_unit_assertions.sv
      - tb/lmem_unit_tb.sv

// File: tb/lmem_unit_tb.sv
// **************************************************
// Random traffic test of the local memory unit, with
// scratchpad and global memory models in the bench
// **************************************************

`timescale 1ns/1ns

`include "lmem_consts.svh"

module lmem_unit_tb;

    localparam int NL = `LMEM_NUM_LANES;
    localparam int NBYTE = `LMEM_BYTEEN_W;

    logic           clk;
    logic           rst_n;
    logic           req_valid;
    logic           req_ready;
    lmem_pkg::req_t req;
    logic           rsp_valid;
    logic           rsp_ready;
    lmem_pkg::rsp_t rsp;
    logic           greq_valid;
    logic           greq_ready;
    lmem_pkg::req_t greq;
    logic           grsp_valid;
    logic           grsp_ready;
    lmem_pkg::rsp_t grsp;

    logic [31:0]             lfsr = 32'hbe9b_d74a;
    logic [`LMEM_WORD_W-1:0] smem [256];
    logic [`LMEM_WORD_W-1:0] gmem [32];
    lmem_pkg::rsp_t          exp_l [256];
    lmem_pkg::rsp_t          exp_g [256];
    bit                      exp_l_valid [256];
    bit                      exp_g_valid [256];
    int                      tag_busy [256];
    lmem_pkg::req_t          greq_exp [$];
    lmem_pkg::req_t          serve_q [$];
    int                      outstanding = 0;
    int                      gdelay = 0;
    logic                    grsp_taken = 1'b0;
    logic                    timed_out = 1'b0;
    int                      rsp_errs = 0;
    int                      greq_errs = 0;
    int                      tmo_errs = 0;

    lmem_tb_clkgen clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    lmem_unit dut0 (.*);

    // Galois LFSR stepped once for each returned bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic lmem_pkg::req_t rand_req(input logic [7:0] tag);
        lmem_pkg::req_t r;
        r = '0;
        r.mask     = 4'(rand_bits(4));
        r.rw       = rand_bits(1) != 0;
        r.is_local = 4'(rand_bits(4));
        r.tag      = tag;
        for (int l = 0; l < NL; l++) begin
            r.byteen[l] = 4'(rand_bits(4));
            r.data[l]   = rand_bits(32);
            // Few rows and words so that lanes often share a bank
            if (r.is_local[l]) begin
                r.addr[l] = rand_bits(4);
            end else begin
                r.addr[l] = 32'h8000_0000 | rand_bits(5);
            end
        end
        return r;
    endfunction

    task automatic check_rsp(input lmem_pkg::rsp_t got, input lmem_pkg::rsp_t exp);
        if (got.mask !== exp.mask || got.tag !== exp.tag) begin
            $display("[ERROR] %0t: response tag %0h mask %b, expected tag %0h mask %b",
                     $time, got.tag, got.mask, exp.tag, exp.mask);
            rsp_errs++;
        end
        for (int l = 0; l < NL; l++) begin
            if (exp.mask[l] && got.data[l] !== exp.data[l]) begin
                $display("[ERROR] %0t: response tag %0h lane %0d data %h, expected %h",
                         $time, got.tag, l, got.data[l], exp.data[l]);
                rsp_errs++;
            end
        end
    endtask

    task automatic check_greq(input lmem_pkg::req_t got, input lmem_pkg::req_t exp);
        if (got.mask !== exp.mask || got.rw !== exp.rw || got.tag !== exp.tag) begin
            $display("[ERROR] %0t: greq tag %0h rw %b mask %b, expected tag %0h rw %b mask %b",
                     $time, got.tag, got.rw, got.mask, exp.tag, exp.rw, exp.mask);
            greq_errs++;
        end
        for (int l = 0; l < NL; l++) begin
            if (exp.mask[l] && (got.addr[l] !== exp.addr[l] || got.data[l] !== exp.data[l]
                    || got.byteen[l] !== exp.byteen[l])) begin
                $display("[ERROR] %0t: greq tag %0h lane %0d addr %h data %h, expected %h %h",
                         $time, got.tag, l, got.addr[l], got.data[l], exp.addr[l], exp.data[l]);
                greq_errs++;
            end
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s", what);
        tmo_errs++;
        timed_out = 1'b1;
    endtask

    // Updates the models, records what must come back, then drives the request
    task automatic send_req(input lmem_pkg::req_t r);
        lmem_pkg::lane_mask_t lm;
        lmem_pkg::lane_mask_t gm;
        lmem_pkg::req_t       g;
        lmem_pkg::rsp_t       e;
        int                   waited;
        lm = r.mask & r.is_local;
        gm = r.mask & ~r.is_local;
        waited = 0;
        while (!timed_out && tag_busy[r.tag] != 0) begin
            @(negedge clk);
            waited++;
            if (waited > 2000) begin
                report_timeout("a tag stayed in use and could not be reissued");
            end
        end
        if (timed_out) begin
            return;
        end
        if (lm != 0 && r.rw) begin
            for (int l = 0; l < NL; l++) begin
                for (int b = 0; b < NBYTE; b++) begin
                    if (lm[l] && r.byteen[l][b]) begin
                        smem[r.addr[l][7:0]][8*b +: 8] = r.data[l][8*b +: 8];
                    end
                end
            end
        end else if (lm != 0) begin
            e = '0;
            e.mask = lm;
            e.tag  = r.tag;
            for (int l = 0; l < NL; l++) begin
                if (lm[l]) begin
                    e.data[l] = smem[r.addr[l][7:0]];
                end
            end
            exp_l[r.tag] = e;
            exp_l_valid[r.tag] = 1'b1;
            tag_busy[r.tag]++;
            outstanding++;
        end
        if (gm != 0) begin
            g = r;
            g.mask = gm;
            greq_exp.push_back(g);
            if (!r.rw) begin
                tag_busy[r.tag]++;
                outstanding++;
            end
        end
        req = r;
        req_valid = 1'b1;
        waited = 0;
        @(posedge clk);
        while (!req_ready) begin
            if (waited == 2000) begin
                report_timeout("a request was never accepted");
                break;
            end
            waited++;
            @(posedge clk);
        end
        @(negedge clk);
        req_valid = 1'b0;
        repeat (rand_bits(1)) @(negedge clk);
    endtask

    // Responses to the core are matched by tag and by the side's lane mask
    always @(posedge clk) begin
        if (rst_n && rsp_valid && rsp_ready) begin
            if (exp_l_valid[rsp.tag] && rsp.mask == exp_l[rsp.tag].mask) begin
                check_rsp(rsp, exp_l[rsp.tag]);
                exp_l_valid[rsp.tag] = 1'b0;
                tag_busy[rsp.tag]--;
                outstanding--;
            end else if (exp_g_valid[rsp.tag] && rsp.mask == exp_g[rsp.tag].mask) begin
                check_rsp(rsp, exp_g[rsp.tag]);
                exp_g_valid[rsp.tag] = 1'b0;
                tag_busy[rsp.tag]--;
                outstanding--;
            end else begin
                $display("[ERROR] %0t: unexpected response with tag %0h mask %b",
                         $time, rsp.tag, rsp.mask);
                rsp_errs++;
            end
        end
    end

    always @(posedge clk) begin
        grsp_taken = grsp_valid && grsp_ready;
        if (rst_n && greq_valid && greq_ready) begin
            if (greq_exp.size() == 0) begin
                $display("[ERROR] %0t: greq with tag %0h while none was expected",
                         $time, greq.tag);
                greq_errs++;
            end else begin
                check_greq(greq, greq_exp.pop_front());
            end
            serve_q.push_back(greq);
        end
    end

    // Global memory model that serves requests in order after a short random delay
    always @(negedge clk) begin : global_mem
        lmem_pkg::req_t g;
        rsp_ready  = rand_bits(2) != 0;
        greq_ready = (rand_bits(1) != 0) && (serve_q.size() < 4);
        if (!(grsp_valid && !grsp_taken)) begin
            grsp_valid = 1'b0;
            if (gdelay != 0) begin
                gdelay--;
            end else if (serve_q.size() != 0) begin
                g = serve_q.pop_front();
                gdelay = int'(rand_bits(2));
                if (g.rw) begin
                    for (int l = 0; l < NL; l++) begin
                        for (int b = 0; b < NBYTE; b++) begin
                            if (g.mask[l] && g.byteen[l][b]) begin
                                gmem[g.addr[l][4:0]][8*b +: 8] = g.data[l][8*b +: 8];
                            end
                        end
                    end
                end else begin
                    grsp = '0;
                    grsp.mask = g.mask;
                    grsp.tag  = g.tag;
                    for (int l = 0; l < NL; l++) begin
                        if (g.mask[l]) begin
                            grsp.data[l] = gmem[g.addr[l][4:0]];
                        end
                    end
                    grsp_valid = 1'b1;
                    exp_g[g.tag] = grsp;
                    exp_g_valid[g.tag] = 1'b1;
                end
            end
        end
    end

    initial begin : stimulus
        lmem_pkg::req_t r;
        logic [7:0]     tag;
        int             waited;
        req_valid  = 1'b0;
        req        = '0;
        rsp_ready  = 1'b0;
        greq_ready = 1'b0;
        grsp_valid = 1'b0;
        grsp       = '0;
        tag        = '0;
        for (int i = 0; i < 32; i++) begin
            gmem[i] = 32'h6b43_a9b5 ^ (32'(i) * 32'h0101_0101);
        end
        waited = 0;
        while (rst_n !== 1'b1 && !timed_out) begin
            @(negedge clk);
            waited++;
            if (waited > 100) begin
                report_timeout("reset was never released");
            end
        end
        @(negedge clk);
        // Full-word writes to every scratchpad word the random phase uses
        for (int i = 0; i < 4; i++) begin
            r = '0;
            r.mask     = '1;
            r.rw       = 1'b1;
            r.is_local = '1;
            r.tag      = tag;
            tag        = tag + 8'd1;
            for (int l = 0; l < NL; l++) begin
                r.addr[l]   = 32'(4 * i + l);
                r.byteen[l] = '1;
                r.data[l]   = rand_bits(32);
            end
            send_req(r);
        end
        // All four lanes in bank 0
        r = rand_req(tag);
        tag = tag + 8'd1;
        r.mask     = '1;
        r.rw       = 1'b0;
        r.is_local = '1;
        r.addr     = {32'd12, 32'd8, 32'd4, 32'd0};
        send_req(r);
        // A mixed read followed by an empty request
        r = rand_req(tag);
        tag = tag + 8'd1;
        r.mask     = '1;
        r.rw       = 1'b0;
        r.is_local = 4'b0101;
        r.addr[0]  = rand_bits(4);
        r.addr[2]  = rand_bits(4);
        send_req(r);
        r = rand_req(tag);
        tag = tag + 8'd1;
        r.mask = '0;
        send_req(r);
        for (int n = 0; n < 600 && !timed_out; n++) begin
            r = rand_req(tag);
            tag = tag + 8'd1;
            send_req(r);
        end
        waited = 0;
        while (!timed_out && (outstanding != 0 || greq_exp.size() != 0)) begin
            @(negedge clk);
            waited++;
            if (waited > 5000) begin
                report_timeout("responses were still missing after the last request");
            end
        end
        // Quiet period in which no stray response may appear
        repeat (20) @(negedge clk);
        $display("Errors: %0d response, %0d global request, %0d timeout",
                 rsp_errs, greq_errs, tmo_errs);
        if (rsp_errs == 0 && greq_errs == 0 && tmo_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: tb/lmem_unit_assertions.sv
// **************************************************
// Handshake checks for the local memory unit, bound
// to every instance of the top level
// **************************************************

`timescale 1ns/1ns

module lmem_unit_assertions (
    input logic           clk,
    input logic           rst_n,
    input logic           req_valid,
    input logic           rsp_valid,
    input logic           rsp_ready,
    input lmem_pkg::rsp_t rsp,
    input logic           greq_valid,
    input logic           greq_ready,
    input lmem_pkg::req_t greq,
    input logic           grsp_valid,
    input logic           grsp_ready,
    input lmem_pkg::rsp_t grsp
);

    // A stalled transfer keeps its valid and its payload until it is taken
    rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else $error("rsp changed while waiting for rsp_ready");

    greq_hold: assert property (@(posedge clk) disable iff (!rst_n)
        greq_valid && !greq_ready |=> greq_valid && $stable(greq))
        else $error("greq changed while waiting for greq_ready");

    grsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        grsp_valid && !grsp_ready |=> grsp_valid && $stable(grsp))
        else $error("grsp changed while waiting for grsp_ready");

    reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !req_valid && !rsp_valid && !greq_valid && !grsp_valid && !grsp_ready)
        else $error("valid or grsp_ready high during reset");

endmodule

bind lmem_unit lmem_unit_assertions unit_checks (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .rsp_valid  (rsp_valid),
    .rsp_ready  (rsp_ready),
    .rsp        (rsp),
    .greq_valid (greq_valid),
    .greq_ready (greq_ready),
    .greq       (greq),
    .grsp_valid (grsp_valid),
    .grsp_ready (grsp_ready),
    .grsp       (grsp)
);

// File: tb/lmem_tb_clkgen.sv
// **************************************************
// Testbench clock (10 ns period) and active-low reset
// held for the first ten cycles
// **************************************************

`timescale 1ns/1ns

module lmem_tb_clkgen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: hw/lmem_unit.sv
// **************************************************
// Local memory unit top level. Splits each request by
// address type between the scratchpad and global port
// **************************************************

`timescale 1ns/1ns

`include "lmem_consts.svh"

module lmem_unit (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           req_valid,
    output logic           req_ready,
    input  lmem_pkg::req_t req,
    output logic           rsp_valid,
    input  logic           rsp_ready,
    output lmem_pkg::rsp_t rsp,
    output logic           greq_valid,
    input  logic           greq_ready,
    output lmem_pkg::req_t greq,
    input  logic           grsp_valid,
    output logic           grsp_ready,
    input  lmem_pkg::rsp_t grsp
);

    lmem_pkg::lane_mask_t                           local_mask;
    lmem_pkg::lane_mask_t                           global_mask;
    logic                                           need_local;
    logic                                           need_global;
    logic                                           req_fire;
    lmem_pkg::req_t                                 local_copy;
    lmem_pkg::req_t                                 global_copy;
    logic                                           gbuf_ready;
    logic                                           local_valid;
    logic                                           local_ready;
    logic                                           coll_ready;
    logic                                           hdr_valid;
    logic [`LMEM_TAG_W-1:0]                         hdr_tag;
    lmem_pkg::lane_mask_t                           hdr_mask;
    logic [`LMEM_NUM_BANKS-1:0]                     bank_en;
    lmem_pkg::bank_req_t [`LMEM_NUM_BANKS-1:0]      bank_req;
    logic [`LMEM_NUM_BANKS-1:0]                     bank_rsp_valid;
    lmem_pkg::bank_rsp_t [`LMEM_NUM_BANKS-1:0]      bank_rsp;
    logic                                           lrsp_valid;
    logic                                           lrsp_ready;
    lmem_pkg::rsp_t                                 lrsp;

    assign local_mask  = req.mask & req.is_local;
    assign global_mask = req.mask & ~req.is_local;
    assign need_local  = |local_mask;
    assign need_global = |global_mask;

    // Both sides must be able to take their part before the request is taken
    assign req_ready = (!need_global || gbuf_ready) && (!need_local || local_ready);
    assign req_fire  = req_valid && req_ready;

    always_comb begin
        local_copy       = req;
        local_copy.mask  = local_mask;
        global_copy      = req;
        global_copy.mask = global_mask;
    end

    assign local_valid = req_fire && need_local;

    lmem_elastic_buf #(
        .payload_t (lmem_pkg::req_t)
    ) greq_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (req_fire && need_global),
        .in_ready  (gbuf_ready),
        .in_data   (global_copy),
        .out_valid (greq_valid),
        .out_ready (greq_ready),
        .out_data  (greq)
    );

    lmem_bank_dispatch dispatch (
        .clk         (clk),
        .rst_n       (rst_n),
        .local_valid (local_valid),
        .local_ready (local_ready),
        .local_req   (local_copy),
        .coll_ready  (coll_ready),
        .hdr_valid   (hdr_valid),
        .hdr_tag     (hdr_tag),
        .hdr_mask    (hdr_mask),
        .bank_en     (bank_en),
        .bank_req    (bank_req)
    );

    for (genvar b = 0; b < `LMEM_NUM_BANKS; b++) begin : g_bank
        lmem_bank bank (
            .clk       (clk),
            .rst_n     (rst_n),
            .en        (bank_en[b]),
            .req       (bank_req[b]),
            .rsp_valid (bank_rsp_valid[b]),
            .rsp       (bank_rsp[b])
        );
    end

    lmem_rsp_collect collect (
        .clk            (clk),
        .rst_n          (rst_n),
        .hdr_valid      (hdr_valid),
        .hdr_tag        (hdr_tag),
        .hdr_mask       (hdr_mask),
        .bank_rsp_valid (bank_rsp_valid),
        .bank_rsp       (bank_rsp),
        .coll_ready     (coll_ready),
        .out_valid      (lrsp_valid),
        .out_ready      (lrsp_ready),
        .out_rsp        (lrsp)
    );

    lmem_rsp_arb rsp_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .lrsp_valid (lrsp_valid),
        .lrsp_ready (lrsp_ready),
        .lrsp       (lrsp),
        .grsp_valid (grsp_valid),
        .grsp_ready (grsp_ready),
        .grsp       (grsp),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp        (rsp)
    );

endmodule

// File: hw/lmem_rsp_arb.sv
// **************************************************
// Round-robin merge of local and global responses,
// grant held until the granted response transfers
// **************************************************

`timescale 1ns/1ns

module lmem_rsp_arb (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           lrsp_valid,
    output logic           lrsp_ready,
    input  lmem_pkg::rsp_t lrsp,
    input  logic           grsp_valid,
    output logic           grsp_ready,
    input  lmem_pkg::rsp_t grsp,
    output logic           rsp_valid,
    input  logic           rsp_ready,
    output lmem_pkg::rsp_t rsp
);

    // Select value 1 means the global input
    logic sel;
    logic locked;
    logic lock_sel;
    logic last_sel;

    always_comb begin
        if (locked) begin
            sel = lock_sel;
        end else if (lrsp_valid && grsp_valid) begin
            sel = ~last_sel;
        end else begin
            sel = grsp_valid;
        end
    end

    assign rsp_valid  = sel ? grsp_valid : lrsp_valid;
    assign rsp        = sel ? grsp : lrsp;
    assign lrsp_ready = rsp_ready && !sel;
    assign grsp_ready = rsp_ready && sel;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            locked   <= 1'b0;
            lock_sel <= 1'b0;
            last_sel <= 1'b1;
        end else begin
            locked   <= rsp_valid && !rsp_ready;
            lock_sel <= sel;
            if (rsp_valid && rsp_ready) begin
                last_sel <= sel;
            end
        end
    end

endmodule

// File: hw/lmem_rsp_collect.sv
// **************************************************
// Reassembles bank read beats into one response per
// local read and queues it toward the arbiter
// **************************************************

`timescale 1ns/1ns

`include "lmem_consts.svh"

module lmem_rsp_collect (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        hdr_valid,
    input  logic [`LMEM_TAG_W-1:0]                      hdr_tag,
    input  lmem_pkg::lane_mask_t                        hdr_mask,
    input  logic [`LMEM_NUM_BANKS-1:0]                  bank_rsp_valid,
    input  lmem_pkg::bank_rsp_t [`LMEM_NUM_BANKS-1:0]   bank_rsp,
    output logic                                        coll_ready,
    output logic                                        out_valid,
    input  logic                                        out_ready,
    output lmem_pkg::rsp_t                              out_rsp
);

    lmem_pkg::lane_mask_t                           remain;
    lmem_pkg::lane_mask_t                           remain_next;
    lmem_pkg::lane_mask_t                           beat_mask;
    lmem_pkg::lane_mask_t                           open_mask;
    logic [`LMEM_TAG_W-1:0]                         open_tag;
    logic [`LMEM_NUM_LANES-1:0][`LMEM_WORD_W-1:0]   open_data;
    logic [`LMEM_NUM_LANES-1:0][`LMEM_WORD_W-1:0]   merged;
    lmem_pkg::rsp_t                                 push_rsp;
    logic                                           push;

    always_comb begin
        merged    = open_data;
        beat_mask = '0;
        for (int b = 0; b < `LMEM_NUM_BANKS; b++) begin
            if (bank_rsp_valid[b]) begin
                merged[bank_rsp[b].lane]    = bank_rsp[b].data;
                beat_mask[bank_rsp[b].lane] = 1'b1;
            end
        end
    end

    assign remain_next = remain & ~beat_mask;

    // The last beat completes the response, which enters the buffer in that cycle
    assign push = (remain != '0) && (remain_next == '0);

    assign push_rsp.mask = open_mask;
    assign push_rsp.data = merged;
    assign push_rsp.tag  = open_tag;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            remain <= '0;
        end else if (hdr_valid) begin
            remain <= hdr_mask;
        end else begin
            remain <= remain_next;
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_valid) begin
            open_mask <= hdr_mask;
            open_tag  <= hdr_tag;
            open_data <= '0;
        end else begin
            open_data <= merged;
        end
    end

    lmem_elastic_buf #(
        .payload_t (lmem_pkg::rsp_t)
    ) rsp_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (push),
        .in_ready  (coll_ready),
        .in_data   (push_rsp),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_rsp)
    );

endmodule

// File: hw/lmem_bank.sv
// **************************************************
// One scratchpad bank with byte-enabled writes and
// read data returned one cycle after the access
// **************************************************

`timescale 1ns/1ns

`include "lmem_consts.svh"

module lmem_bank (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                en,
    input  lmem_pkg::bank_req_t req,
    output logic                rsp_valid,
    output lmem_pkg::bank_rsp_t rsp
);

    logic [`LMEM_WORD_W-1:0] mem [`LMEM_BANK_DEPTH];

    always_ff @(posedge clk) begin
        if (en && req.rw) begin
            for (int i = 0; i < `LMEM_BYTEEN_W; i++) begin
                if (req.byteen[i]) begin
                    mem[req.row][i*8 +: 8] <= req.data[i*8 +: 8];
                end
            end
        end
        if (en && !req.rw) begin
            rsp.data <= mem[req.row];
            rsp.lane <= req.lane;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= en && !req.rw;
        end
    end

endmodule

// File: hw/lmem_bank_dispatch.sv
// **************************************************
// Issues the local lanes of one request to the banks,
// one lane per bank per cycle, until all are sent
// **************************************************

`timescale 1ns/1ns

`include "lmem_consts.svh"

module lmem_bank_dispatch (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        local_valid,
    output logic                                        local_ready,
    input  lmem_pkg::req_t                              local_req,
    input  logic                                        coll_ready,
    output logic                                        hdr_valid,
    output logic [`LMEM_TAG_W-1:0]                      hdr_tag,
    output lmem_pkg::lane_mask_t                        hdr_mask,
    output logic [`LMEM_NUM_BANKS-1:0]                  bank_en,
    output lmem_pkg::bank_req_t [`LMEM_NUM_BANKS-1:0]   bank_req
);

    localparam int NL     = `LMEM_NUM_LANES;
    localparam int NB     = `LMEM_NUM_BANKS;
    localparam int LANE_W = `LMEM_LANE_W;

    lmem_pkg::req_t       cur_req;
    lmem_pkg::lane_mask_t pending;
    lmem_pkg::lane_mask_t issue_mask;
    logic                 busy;
    logic                 accept;
    logic                 can_issue;

    assign local_ready = !busy;
    assign accept      = local_valid && local_ready;
    assign can_issue   = busy && coll_ready;

    // The collector opens its header in the same cycle the read is taken
    assign hdr_valid = accept && !local_req.rw;
    assign hdr_tag   = local_req.tag;
    assign hdr_mask  = local_req.mask;

    always_comb begin
        bank_en    = '0;
        bank_req   = '0;
        issue_mask = '0;
        for (int b = 0; b < NB; b++) begin
            // Walk lanes downward so the lowest pending lane wins the bank
            for (int l = NL - 1; l >= 0; l--) begin
                if (can_issue && pending[l]
                        && int'(cur_req.addr[l][`LMEM_BANK_SEL_W-1:0]) == b) begin
                    bank_en[b]         = 1'b1;
                    bank_req[b].rw     = cur_req.rw;
                    bank_req[b].byteen = cur_req.byteen[l];
                    bank_req[b].row    = cur_req.addr[l][`LMEM_ADDR_W-1:`LMEM_BANK_SEL_W];
                    bank_req[b].data   = cur_req.data[l];
                    bank_req[b].lane   = LANE_W'(l);
                end
            end
            if (bank_en[b]) begin
                issue_mask[bank_req[b].lane] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            pending <= '0;
        end else if (accept) begin
            busy    <= |local_req.mask;
            pending <= local_req.mask;
        end else if (busy) begin
            busy    <= |(pending & ~issue_mask);
            pending <= pending & ~issue_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cur_req <= local_req;
        end
    end

endmodule

// File: hw/lmem_elastic_buf.sv
// **************************************************
// Two-entry valid/ready FIFO with registered output,
// payload type chosen by parameter
// **************************************************

`timescale 1ns/1ns

module lmem_elastic_buf #(
    parameter type payload_t = lmem_pkg::req_t
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    payload_t   mem [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    assign in_ready  = (count != 2'd2);
    assign out_valid = (count != 2'd0);
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            // Simultaneous push and pop leave the fill level unchanged
            count <= count + {1'b0, push} - {1'b0, pop};
        end
    end

endmodule

// File: hw/lmem_pkg.sv
// **************************************************
// Request, response and bank beat types of the local
// memory unit, shared by the RTL and the testbench
// **************************************************

`include "lmem_consts.svh"

package lmem_pkg;

    typedef logic [`LMEM_NUM_LANES-1:0] lane_mask_t;

    typedef struct packed {
        lane_mask_t                                        mask;
        logic                                              rw;
        logic [`LMEM_NUM_LANES-1:0][`LMEM_BYTEEN_W-1:0]    byteen;
        logic [`LMEM_NUM_LANES-1:0][`LMEM_GADDR_W-1:0]     addr;
        lane_mask_t                                        is_local;
        logic [`LMEM_NUM_LANES-1:0][`LMEM_WORD_W-1:0]      data;
        logic [`LMEM_TAG_W-1:0]                            tag;
    } req_t;

    typedef struct packed {
        lane_mask_t                                        mask;
        logic [`LMEM_NUM_LANES-1:0][`LMEM_WORD_W-1:0]      data;
        logic [`LMEM_TAG_W-1:0]                            tag;
    } rsp_t;

    // One lane's access to one scratchpad bank
    typedef struct packed {
        logic                        rw;
        logic [`LMEM_BYTEEN_W-1:0]   byteen;
        logic [`LMEM_ROW_W-1:0]      row;
        logic [`LMEM_WORD_W-1:0]     data;
        logic [`LMEM_LANE_W-1:0]     lane;
    } bank_req_t;

    typedef struct packed {
        logic [`LMEM_WORD_W-1:0]     data;
        logic [`LMEM_LANE_W-1:0]     lane;
    } bank_rsp_t;

endpackage

// File: hw/lmem_consts.svh
// **************************************************
// Sizing constants for the shared local memory unit
// Include in every file that sizes ports or arrays
// **************************************************

`ifndef LMEM_CONSTS_SVH
`define LMEM_CONSTS_SVH

`define LMEM_NUM_LANES   4
// Must stay a power of two so the low address bits select the bank
`define LMEM_NUM_BANKS   4
`define LMEM_BANK_DEPTH  64
`define LMEM_ADDR_W      8
`define LMEM_WORD_W      32
`define LMEM_TAG_W       8
`define LMEM_GADDR_W     32

`define LMEM_BANK_SEL_W  2
`define LMEM_ROW_W       6
`define LMEM_LANE_W      2
`define LMEM_BYTEEN_W    4

`endif
